/* hw/rv_core_cfg.svh */
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// --------------------------------------------------
// Core widths and reset vector
// --------------------------------------------------

// Data path and address width
`define RV_XLEN 32

// Register index width and register count
`define RV_REG_AW 5
`define RV_NREGS 32

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif

/* hw/rv_core_pkg.sv */
package rv_core_pkg;

  // --------------------------------------------------
  // Major opcodes, instr[6:0]
  // --------------------------------------------------
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // ALU operations, PASS_B forwards operand b for LUI
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  // Write-back source
  typedef enum logic [1:0] {
    RES_ALU,
    RES_MEM,
    RES_PC4
  } res_src_e;

  // Next-PC choice
  typedef enum logic {
    PC_SEL_SEQ,
    PC_SEL_TARGET
  } pc_sel_e;

endpackage

/* hw/rv_fetch.sv */
`timescale 1ns/1ps

`include "rv_core_cfg.svh"

module rv_fetch (
  input  logic                   clk,
  input  logic                   rst_n,
  input  rv_core_pkg::pc_sel_e   pc_sel,
  input  logic [`RV_XLEN-1:0]    jb_target,
  input  logic                   is_ebreak,
  input  logic                   is_illegal,
  output logic [`RV_XLEN-1:0]    pc,
  output logic [`RV_XLEN-1:0]    pc_plus4,
  output logic                   halt,
  output logic                   ebreak,
  output logic                   trap
);

  import rv_core_pkg::*;

  // Sequential address
  assign pc_plus4 = pc + `RV_XLEN'(4);

  // Either flag stops the core until reset
  assign halt = ebreak || trap;

  // --------------------------------------------------
  // PC register and sticky halt flags
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc     <= `RV_RESET_PC;
      ebreak <= 1'b0;
      trap   <= 1'b0;
    end else if (!halt) begin
      // Flags latch at the edge that ends the offending instruction
      ebreak <= is_ebreak;
      trap   <= is_illegal;
      // PC stays on the halting instruction
      if (!is_ebreak && !is_illegal) begin
        pc <= (pc_sel == PC_SEL_TARGET) ? jb_target : pc_plus4;
      end
    end
  end

endmodule

/* hw/rv_decode.sv */
`timescale 1ns/1ps

`include "rv_core_cfg.svh"

module rv_decode (
  input  logic [31:0]              instr,
  input  logic                     halt,
  output logic [`RV_REG_AW-1:0]    rs1,
  output logic [`RV_REG_AW-1:0]    rs2,
  output logic [`RV_REG_AW-1:0]    rd,
  output logic [`RV_XLEN-1:0]      imm,
  output rv_core_pkg::alu_op_e     alu_op,
  output logic                     alu_a_pc,
  output logic                     alu_b_imm,
  output rv_core_pkg::res_src_e    res_src,
  output logic                     reg_write,
  output logic                     mem_read,
  output logic                     mem_write,
  output logic                     is_branch,
  output logic                     is_jal,
  output logic                     is_jalr,
  output logic [2:0]               funct3,
  output logic                     is_ebreak,
  output logic                     is_illegal
);

  import rv_core_pkg::*;

  opcode_e                opcode;
  logic [6:0]             funct7;
  logic [`RV_XLEN-1:0]    imm_i;
  logic [`RV_XLEN-1:0]    imm_s;
  logic [`RV_XLEN-1:0]    imm_b;
  logic [`RV_XLEN-1:0]    imm_u;
  logic [`RV_XLEN-1:0]    imm_j;
  alu_op_e                alu_op_f3;
  logic                   reg_write_raw;
  logic                   mem_read_raw;
  logic                   mem_write_raw;
  logic                   illegal;

  // --------------------------------------------------
  // Field extraction
  // --------------------------------------------------
  assign opcode = opcode_e'(instr[6:0]);
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign funct7 = instr[31:25];

  // Immediates, all sign-extended from instr[31]
  assign imm_i = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
  assign imm_s = {{(`RV_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{(`RV_XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                  instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{(`RV_XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                  instr[30:21], 1'b0};

  // ALU operation for OP and OP_IMM
  always_comb begin
    case (funct3)
      3'b000:  alu_op_f3 = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
      3'b001:  alu_op_f3 = ALU_SLL;
      3'b010:  alu_op_f3 = ALU_SLT;
      3'b011:  alu_op_f3 = ALU_SLTU;
      3'b100:  alu_op_f3 = ALU_XOR;
      3'b101:  alu_op_f3 = funct7[5] ? ALU_SRA : ALU_SRL;
      3'b110:  alu_op_f3 = ALU_OR;
      default: alu_op_f3 = ALU_AND;
    endcase
  end

  // --------------------------------------------------
  // Control decode
  // --------------------------------------------------
  always_comb begin
    imm           = imm_i;
    alu_op        = ALU_ADD;
    alu_a_pc      = 1'b0;
    alu_b_imm     = 1'b0;
    res_src       = RES_ALU;
    reg_write_raw = 1'b0;
    mem_read_raw  = 1'b0;
    mem_write_raw = 1'b0;
    is_branch     = 1'b0;
    is_jal        = 1'b0;
    is_jalr       = 1'b0;
    is_ebreak     = 1'b0;
    illegal       = 1'b0;

    case (opcode)
      OPC_LUI: begin
        imm           = imm_u;
        alu_op        = ALU_PASS_B;
        alu_b_imm     = 1'b1;
        reg_write_raw = 1'b1;
      end
      OPC_AUIPC: begin
        imm           = imm_u;
        alu_a_pc      = 1'b1;
        alu_b_imm     = 1'b1;
        reg_write_raw = 1'b1;
      end
      OPC_JAL: begin
        imm           = imm_j;
        res_src       = RES_PC4;
        reg_write_raw = 1'b1;
        is_jal        = 1'b1;
      end
      OPC_JALR: begin
        res_src       = RES_PC4;
        reg_write_raw = 1'b1;
        is_jalr       = 1'b1;
        illegal       = (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        imm       = imm_b;
        is_branch = 1'b1;
        // funct3 010 and 011 are reserved
        illegal   = (funct3[2:1] == 2'b01);
      end
      OPC_LOAD: begin
        alu_b_imm     = 1'b1;
        res_src       = RES_MEM;
        reg_write_raw = 1'b1;
        mem_read_raw  = 1'b1;
        // Word loads only
        illegal       = (funct3 != 3'b010);
      end
      OPC_STORE: begin
        imm           = imm_s;
        alu_b_imm     = 1'b1;
        mem_write_raw = 1'b1;
        illegal       = (funct3 != 3'b010);
      end
      OPC_OP_IMM: begin
        alu_op        = alu_op_f3;
        alu_b_imm     = 1'b1;
        reg_write_raw = 1'b1;
        // Shift immediates carry funct7 in the upper bits
        if (funct3 == 3'b001) begin
          illegal = (funct7 != 7'b0000000);
        end else if (funct3 == 3'b101) begin
          illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
        end
      end
      OPC_OP: begin
        alu_op        = alu_op_f3;
        reg_write_raw = 1'b1;
        // Alternate funct7 only for SUB and SRA
        illegal = (funct7 != 7'b0000000) &&
                  !((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      OPC_SYSTEM: begin
        // EBREAK is the only system instruction kept
        is_ebreak = (instr == 32'h0010_0073);
        illegal   = !is_ebreak;
      end
      default: illegal = 1'b1;
    endcase
  end

  assign is_illegal = illegal;

  // Illegal instructions and the halted core write nothing
  assign reg_write = reg_write_raw && !illegal && !halt;
  assign mem_read  = mem_read_raw && !illegal && !halt;
  assign mem_write = mem_write_raw && !illegal && !halt;

endmodule

/* hw/rv_regfile.sv */
`timescale 1ns/1ps

`include "rv_core_cfg.svh"

module rv_regfile (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`RV_REG_AW-1:0]  rs1,
  input  logic [`RV_REG_AW-1:0]  rs2,
  input  logic [`RV_REG_AW-1:0]  rd,
  input  logic [`RV_XLEN-1:0]    rd_data,
  input  logic                   reg_write,
  output logic [`RV_XLEN-1:0]    rs1_data,
  output logic [`RV_XLEN-1:0]    rs2_data
);

  logic [`RV_XLEN-1:0] regs [`RV_NREGS];

  // Write port, x0 never written
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_write && (rd != '0)) begin
      regs[rd] <= rd_data;
    end
  end

  // Combinational read ports, x0 reads zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* hw/rv_execute.sv */
`timescale 1ns/1ps

`include "rv_core_cfg.svh"

module rv_execute (
  input  logic [`RV_XLEN-1:0]    pc,
  input  logic [`RV_XLEN-1:0]    rs1_data,
  input  logic [`RV_XLEN-1:0]    rs2_data,
  input  logic [`RV_XLEN-1:0]    imm,
  input  rv_core_pkg::alu_op_e   alu_op,
  input  logic                   alu_a_pc,
  input  logic                   alu_b_imm,
  input  logic                   is_branch,
  input  logic                   is_jal,
  input  logic                   is_jalr,
  input  logic [2:0]             funct3,
  output logic [`RV_XLEN-1:0]    alu_result,
  output logic [`RV_XLEN-1:0]    jb_target,
  output rv_core_pkg::pc_sel_e   pc_sel
);

  import rv_core_pkg::*;

  logic [`RV_XLEN-1:0] a;
  logic [`RV_XLEN-1:0] b;
  logic [4:0]          shamt;
  logic [`RV_XLEN-1:0] jalr_sum;
  logic                eq;
  logic                lt;
  logic                ltu;
  logic                taken;

  // --------------------------------------------------
  // ALU
  // --------------------------------------------------
  assign a     = alu_a_pc ? pc : rs1_data;
  assign b     = alu_b_imm ? imm : rs2_data;
  assign shamt = b[4:0];

  always_comb begin
    case (alu_op)
      ALU_ADD:    alu_result = a + b;
      ALU_SUB:    alu_result = a - b;
      ALU_SLL:    alu_result = a << shamt;
      ALU_SLT:    alu_result = {{(`RV_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      ALU_SLTU:   alu_result = {{(`RV_XLEN-1){1'b0}}, a < b};
      ALU_XOR:    alu_result = a ^ b;
      ALU_SRL:    alu_result = a >> shamt;
      ALU_SRA:    alu_result = $signed(a) >>> shamt;
      ALU_OR:     alu_result = a | b;
      ALU_AND:    alu_result = a & b;
      ALU_PASS_B: alu_result = b;
      default:    alu_result = '0;
    endcase
  end

  // --------------------------------------------------
  // Branch compare, always on register operands
  // --------------------------------------------------
  assign eq  = (rs1_data == rs2_data);
  assign lt  = ($signed(rs1_data) < $signed(rs2_data));
  assign ltu = (rs1_data < rs2_data);

  always_comb begin
    case (funct3)
      3'b000:  taken = eq;
      3'b001:  taken = !eq;
      3'b100:  taken = lt;
      3'b101:  taken = !lt;
      3'b110:  taken = ltu;
      3'b111:  taken = !ltu;
      default: taken = 1'b0;
    endcase
  end

  // JALR clears bit 0 of rs1 + imm
  assign jalr_sum  = rs1_data + imm;
  assign jb_target = is_jalr ? {jalr_sum[`RV_XLEN-1:1], 1'b0} : pc + imm;

  assign pc_sel = (is_jal || is_jalr || (is_branch && taken)) ? PC_SEL_TARGET
                                                              : PC_SEL_SEQ;

endmodule

/* hw/rv_mem_wb.sv */
`timescale 1ns/1ps

`include "rv_core_cfg.svh"

module rv_mem_wb (
  input  logic                     halt,
  input  logic [`RV_XLEN-1:0]      alu_result,
  input  logic [`RV_XLEN-1:0]      rs2_data,
  input  logic [`RV_XLEN-1:0]      pc_plus4,
  input  rv_core_pkg::res_src_e    res_src,
  input  logic                     mem_read,
  input  logic                     mem_write,
  output logic                     dmem_ren,
  output logic [`RV_XLEN-1:0]      dmem_raddr,
  input  logic [`RV_XLEN-1:0]      dmem_rdata,
  output logic                     dmem_we,
  output logic [`RV_XLEN-1:0]      dmem_waddr,
  output logic [`RV_XLEN-1:0]      dmem_wdata,
  output logic [`RV_XLEN/8-1:0]    dmem_wstrb,
  output logic [`RV_XLEN-1:0]      rd_data
);

  import rv_core_pkg::*;

  // --------------------------------------------------
  // Data memory, word accesses only
  // --------------------------------------------------
  assign dmem_ren   = mem_read && !halt;
  assign dmem_raddr = alu_result;

  assign dmem_we    = mem_write && !halt;
  assign dmem_waddr = alu_result;
  assign dmem_wdata = rs2_data;
  assign dmem_wstrb = '1;

  // Write-back select
  always_comb begin
    case (res_src)
      RES_MEM: rd_data = dmem_rdata;
      RES_PC4: rd_data = pc_plus4;
      default: rd_data = alu_result;
    endcase
  end

endmodule

/* hw/rv_core.sv */
`timescale 1ns/1ps

`include "rv_core_cfg.svh"

module rv_core (
  input  logic                   clk,
  input  logic                   rst_n,

  // Instruction memory, same-cycle read
  output logic                   imem_ren,
  output logic [`RV_XLEN-1:0]    imem_raddr,
  input  logic [31:0]            imem_rdata,

  // Data memory read side
  output logic                   dmem_ren,
  output logic [`RV_XLEN-1:0]    dmem_raddr,
  input  logic [`RV_XLEN-1:0]    dmem_rdata,

  // Data memory write side
  output logic                   dmem_we,
  output logic [`RV_XLEN-1:0]    dmem_waddr,
  output logic [`RV_XLEN-1:0]    dmem_wdata,
  output logic [`RV_XLEN/8-1:0]  dmem_wstrb,

  output logic                   ebreak,
  output logic                   trap
);

  import rv_core_pkg::*;

  // --------------------------------------------------
  // Stage-to-stage wires
  // --------------------------------------------------

  // Fetch
  logic [`RV_XLEN-1:0]    pc;
  logic [`RV_XLEN-1:0]    pc_plus4;
  logic                   halt;

  // Decode
  logic [`RV_REG_AW-1:0]  rs1;
  logic [`RV_REG_AW-1:0]  rs2;
  logic [`RV_REG_AW-1:0]  rd;
  logic [`RV_XLEN-1:0]    imm;
  alu_op_e                alu_op;
  logic                   alu_a_pc;
  logic                   alu_b_imm;
  res_src_e               res_src;
  logic                   reg_write;
  logic                   mem_read;
  logic                   mem_write;
  logic                   is_branch;
  logic                   is_jal;
  logic                   is_jalr;
  logic [2:0]             funct3;
  logic                   is_ebreak;
  logic                   is_illegal;

  // Register file and execute
  logic [`RV_XLEN-1:0]    rs1_data;
  logic [`RV_XLEN-1:0]    rs2_data;
  logic [`RV_XLEN-1:0]    alu_result;
  logic [`RV_XLEN-1:0]    jb_target;
  pc_sel_e                pc_sel;
  logic [`RV_XLEN-1:0]    rd_data;

  // Fetch stops once halted
  assign imem_ren   = !halt;
  assign imem_raddr = pc;

  rv_fetch rv_fetch_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .pc_sel     (pc_sel),
    .jb_target  (jb_target),
    .is_ebreak  (is_ebreak),
    .is_illegal (is_illegal),
    .pc         (pc),
    .pc_plus4   (pc_plus4),
    .halt       (halt),
    .ebreak     (ebreak),
    .trap       (trap)
  );

  rv_decode rv_decode_i (
    .instr      (imem_rdata),
    .halt       (halt),
    .rs1        (rs1),
    .rs2        (rs2),
    .rd         (rd),
    .imm        (imm),
    .alu_op     (alu_op),
    .alu_a_pc   (alu_a_pc),
    .alu_b_imm  (alu_b_imm),
    .res_src    (res_src),
    .reg_write  (reg_write),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .is_branch  (is_branch),
    .is_jal     (is_jal),
    .is_jalr    (is_jalr),
    .funct3     (funct3),
    .is_ebreak  (is_ebreak),
    .is_illegal (is_illegal)
  );

  rv_regfile rv_regfile_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .rd_data   (rd_data),
    .reg_write (reg_write),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data)
  );

  rv_execute rv_execute_i (
    .pc         (pc),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .imm        (imm),
    .alu_op     (alu_op),
    .alu_a_pc   (alu_a_pc),
    .alu_b_imm  (alu_b_imm),
    .is_branch  (is_branch),
    .is_jal     (is_jal),
    .is_jalr    (is_jalr),
    .funct3     (funct3),
    .alu_result (alu_result),
    .jb_target  (jb_target),
    .pc_sel     (pc_sel)
  );

  rv_mem_wb rv_mem_wb_i (
    .halt       (halt),
    .alu_result (alu_result),
    .rs2_data   (rs2_data),
    .pc_plus4   (pc_plus4),
    .res_src    (res_src),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .dmem_ren   (dmem_ren),
    .dmem_raddr (dmem_raddr),
    .dmem_rdata (dmem_rdata),
    .dmem_we    (dmem_we),
    .dmem_waddr (dmem_waddr),
    .dmem_wdata (dmem_wdata),
    .dmem_wstrb (dmem_wstrb),
    .rd_data    (rd_data)
  );

endmodule

/* verification/rv_core_tb.sv */
`timescale 1ns/1ps

`include "rv_core_cfg.svh"

module rv_core_tb;

  import rv_core_pkg::*;

  localparam int NPHASES    = 6;
  localparam int IMEM_WORDS = 64;
  localparam int DMEM_WORDS = 256;
  localparam logic [31:0] EBREAK_INSTR = 32'h0010_0073;

  // DUT connections
  logic                   clk = 1'b0;
  logic                   rst_n = 1'b0;
  logic                   imem_ren;
  logic [`RV_XLEN-1:0]    imem_raddr;
  logic [31:0]            imem_rdata;
  logic                   dmem_ren;
  logic [`RV_XLEN-1:0]    dmem_raddr;
  logic [`RV_XLEN-1:0]    dmem_rdata;
  logic                   dmem_we;
  logic [`RV_XLEN-1:0]    dmem_waddr;
  logic [`RV_XLEN-1:0]    dmem_wdata;
  logic [`RV_XLEN/8-1:0]  dmem_wstrb;
  logic                   ebreak;
  logic                   trap;

  // Word-addressed memories
  logic [31:0]            imem [IMEM_WORDS];
  logic [`RV_XLEN-1:0]    dmem [DMEM_WORDS];

  // Program table and store expectations split into phases
  logic [31:0] prog [$];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  int          prog_start [NPHASES];
  int          prog_len [NPHASES];
  int          exp_start [NPHASES];
  int          exp_len [NPHASES];
  bit          exp_trap [NPHASES];
  int          nph;

  // Table build state
  logic [11:0] st_addr;
  logic [11:0] mark;
  logic [31:0] op_a;
  logic [31:0] op_b;

  int checks;
  int value_errors;
  int flow_errors;
  int cycle_count;
  int cycle_limit;

  // --------------------------------------------------
  // Clock, DUT, memory models, timeout
  // --------------------------------------------------
  always #5 clk = ~clk;

  rv_core rv_core_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_ren   (imem_ren),
    .imem_raddr (imem_raddr),
    .imem_rdata (imem_rdata),
    .dmem_ren   (dmem_ren),
    .dmem_raddr (dmem_raddr),
    .dmem_rdata (dmem_rdata),
    .dmem_we    (dmem_we),
    .dmem_waddr (dmem_waddr),
    .dmem_wdata (dmem_wdata),
    .dmem_wstrb (dmem_wstrb),
    .ebreak     (ebreak),
    .trap       (trap)
  );

  // Same-cycle reads deliver data only while the enable is high
  assign imem_rdata = imem_ren ? imem[imem_raddr[7:2]] : '0;
  assign dmem_rdata = dmem_ren ? dmem[dmem_raddr[9:2]] : '0;

  // Edge write ignored while reset is held
  always @(posedge clk) begin
    if (rst_n && dmem_we) begin
      dmem[dmem_waddr[9:2]] <= dmem_wdata;
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout after %0d cycles, the core never reached the expected halt",
               cycle_count);
      $display("TEST FAILED");
      $finish;
    end
  end

  // --------------------------------------------------
  // Instruction encoders
  // --------------------------------------------------
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] i_type(input opcode_e opc, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  // Word store only
  function automatic logic [31:0] s_type(input logic [4:0] rs2, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] u_type(input opcode_e opc, input logic [4:0] rd,
                                         input logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  // RV32I branch condition by funct3
  function automatic bit branch_outcome(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  // --------------------------------------------------
  // Table building
  // --------------------------------------------------
  task automatic push_instr(input logic [31:0] w);
    prog.push_back(w);
  endtask

  task automatic expect_store(input logic [31:0] a, input logic [31:0] d);
    exp_addr.push_back(a);
    exp_data.push_back(d);
  endtask

  // Address of the next instruction within the open phase
  function automatic logic [31:0] pc_here();
    return 32'((prog.size() - prog_start[nph]) * 4);
  endfunction

  task automatic open_phase(input bit trap_expected);
    prog_start[nph] = prog.size();
    exp_start[nph]  = exp_addr.size();
    exp_trap[nph]   = trap_expected;
  endtask

  task automatic close_phase();
    prog_len[nph] = prog.size() - prog_start[nph];
    exp_len[nph]  = exp_addr.size() - exp_start[nph];
    nph++;
  endtask

  // Instruction writes x3 and a store copies x3 to the next result slot
  task automatic result_and_store(input logic [31:0] instr, input logic [31:0] expected);
    push_instr(instr);
    push_instr(s_type(5'd3, 5'd0, st_addr));
    expect_store({20'd0, st_addr}, expected);
    st_addr += 12'd4;
  endtask

  task automatic branch_probe(input logic [2:0] f3, input logic [4:0] ra,
                              input logic [4:0] rb, input logic [31:0] va,
                              input logic [31:0] vb);
    mark += 12'd1;
    push_instr(i_type(OPC_OP_IMM, 3'b000, 5'd5, 5'd0, mark));
    // Taken branch jumps over the marker store
    push_instr(b_type(f3, ra, rb, 13'd8));
    push_instr(s_type(5'd5, 5'd0, st_addr));
    if (!branch_outcome(f3, va, vb)) begin
      expect_store({20'd0, st_addr}, {20'd0, mark});
    end
    st_addr += 12'd4;
  endtask

  task automatic build_tables();
    logic [2:0]  br_f3 [6];
    logic [31:0] neg3;
    logic [31:0] pos5;
    br_f3   = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    neg3    = 32'hffff_fffd;
    pos5    = 32'd5;
    st_addr = 12'h200;
    mark    = 12'd0;

    // ALU ops on random operands from data memory
    open_phase(1'b0);
    push_instr(i_type(OPC_LOAD, 3'b010, 5'd1, 5'd0, 12'h100));
    push_instr(i_type(OPC_LOAD, 3'b010, 5'd2, 5'd0, 12'h104));
    result_and_store(r_type(7'h00, 3'b000, 5'd3, 5'd1, 5'd2), op_a + op_b);
    result_and_store(r_type(7'h20, 3'b000, 5'd3, 5'd1, 5'd2), op_a - op_b);
    result_and_store(r_type(7'h00, 3'b001, 5'd3, 5'd1, 5'd2), op_a << op_b[4:0]);
    result_and_store(r_type(7'h00, 3'b010, 5'd3, 5'd1, 5'd2),
                     ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0);
    result_and_store(r_type(7'h00, 3'b011, 5'd3, 5'd1, 5'd2),
                     (op_a < op_b) ? 32'd1 : 32'd0);
    result_and_store(r_type(7'h00, 3'b100, 5'd3, 5'd1, 5'd2), op_a ^ op_b);
    result_and_store(r_type(7'h00, 3'b101, 5'd3, 5'd1, 5'd2), op_a >> op_b[4:0]);
    result_and_store(r_type(7'h20, 3'b101, 5'd3, 5'd1, 5'd2),
                     32'($signed(op_a) >>> op_b[4:0]));
    result_and_store(r_type(7'h00, 3'b110, 5'd3, 5'd1, 5'd2), op_a | op_b);
    result_and_store(r_type(7'h00, 3'b111, 5'd3, 5'd1, 5'd2), op_a & op_b);
    result_and_store(i_type(OPC_OP_IMM, 3'b000, 5'd3, 5'd1, 12'hffb), op_a + 32'hffff_fffb);
    result_and_store(i_type(OPC_OP_IMM, 3'b101, 5'd3, 5'd1, 12'h407),
                     32'($signed(op_a) >>> 7));
    // Immediate 0x800 sign-extends to 0xfffff800
    result_and_store(i_type(OPC_OP_IMM, 3'b011, 5'd3, 5'd1, 12'h800),
                     (op_a < 32'hffff_f800) ? 32'd1 : 32'd0);
    push_instr(EBREAK_INSTR);
    close_phase();

    // Upper immediates where AUIPC adds its own address
    open_phase(1'b0);
    result_and_store(u_type(OPC_LUI, 5'd3, 20'h12345), 32'h1234_5000);
    result_and_store(u_type(OPC_AUIPC, 5'd3, 20'habcde), 32'habcd_e000 + pc_here());
    result_and_store(u_type(OPC_AUIPC, 5'd3, 20'h00000), pc_here());
    result_and_store(u_type(OPC_LUI, 5'd3, 20'h80000), 32'h8000_0000);
    push_instr(EBREAK_INSTR);
    close_phase();

    // All six branches both taken and not taken
    open_phase(1'b0);
    push_instr(i_type(OPC_OP_IMM, 3'b000, 5'd1, 5'd0, 12'hffd));
    push_instr(i_type(OPC_OP_IMM, 3'b000, 5'd2, 5'd0, 12'h005));
    foreach (br_f3[k]) begin
      branch_probe(br_f3[k], 5'd1, 5'd2, neg3, pos5);
      if (br_f3[k][2]) begin
        branch_probe(br_f3[k], 5'd2, 5'd1, pos5, neg3);
      end else begin
        branch_probe(br_f3[k], 5'd1, 5'd1, neg3, neg3);
      end
    end
    push_instr(EBREAK_INSTR);
    close_phase();

    // JAL to 8 links 4
    // JALR to (21+4)&~1 = 24 links 20
    open_phase(1'b0);
    push_instr(j_type(5'd1, 21'd8));
    push_instr(s_type(5'd0, 5'd0, 12'h3f0));
    push_instr(s_type(5'd1, 5'd0, st_addr));
    expect_store({20'd0, st_addr}, 32'd4);
    st_addr += 12'd4;
    push_instr(i_type(OPC_OP_IMM, 3'b000, 5'd6, 5'd0, 12'd21));
    push_instr(i_type(OPC_JALR, 3'b000, 5'd7, 5'd6, 12'd4));
    push_instr(s_type(5'd0, 5'd0, 12'h3f0));
    push_instr(s_type(5'd7, 5'd0, st_addr));
    expect_store({20'd0, st_addr}, 32'd20);
    st_addr += 12'd4;
    push_instr(EBREAK_INSTR);
    close_phase();

    // Store before EBREAK lands and the one after it never issues
    open_phase(1'b0);
    result_and_store(i_type(OPC_OP_IMM, 3'b000, 5'd3, 5'd0, 12'h077), 32'h0000_0077);
    push_instr(EBREAK_INSTR);
    push_instr(s_type(5'd3, 5'd0, 12'h3f4));
    close_phase();

    // Byte load is outside the subset and traps
    open_phase(1'b1);
    push_instr(i_type(OPC_LOAD, 3'b000, 5'd3, 5'd0, 12'h100));
    push_instr(s_type(5'd3, 5'd0, 12'h3f8));
    push_instr(EBREAK_INSTR);
    close_phase();
  endtask

  // --------------------------------------------------
  // Phase execution and checks
  // --------------------------------------------------
  task automatic fill_imem();
    for (int i = 0; i < IMEM_WORDS; i++) begin
      // Opcode zero is illegal so a runaway fetch traps
      imem[i] = {25'(i), 7'b0000000};
    end
  endtask

  task automatic check_store(inout int idx, input int last);
    if (idx >= last) begin
      flow_errors++;
      $display("Unexpected store of %h to %h at %0t", dmem_wdata, dmem_waddr, $time);
    end else begin
      checks++;
      if (dmem_waddr !== exp_addr[idx]) begin
        value_errors++;
        $display("** Error at %0t: dmem_waddr expected %h, got %h",
                 $time, exp_addr[idx], dmem_waddr);
      end
      if (dmem_wdata !== exp_data[idx]) begin
        value_errors++;
        $display("** Error at %0t: dmem_wdata expected %h, got %h",
                 $time, exp_data[idx], dmem_wdata);
      end
      if (dmem_wstrb !== 4'hf) begin
        value_errors++;
        $display("** Error at %0t: dmem_wstrb expected f, got %h", $time, dmem_wstrb);
      end
      idx++;
    end
  endtask

  task automatic run_phase(input int p);
    logic [31:0] held_pc;
    logic        exp_eb;
    int          idx;
    int          last;
    idx    = exp_start[p];
    last   = exp_start[p] + exp_len[p];
    exp_eb = ~exp_trap[p];

    // Load the program while reset is held
    @(posedge clk);
    #1;
    rst_n = 1'b0;
    fill_imem();
    for (int i = 0; i < prog_len[p]; i++) begin
      imem[i] = prog[prog_start[p] + i];
    end
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Run to halt with outputs sampled mid-cycle
    while (!(ebreak || trap)) begin
      @(negedge clk);
      if (dmem_we) begin
        check_store(idx, last);
      end
    end

    // Halted core stays frozen
    held_pc = imem_raddr;
    repeat (10) begin
      @(negedge clk);
      if (dmem_we) begin
        flow_errors++;
        $display("Phase %0d: store to %h issued while halted at %0t", p, dmem_waddr, $time);
      end
      if (imem_raddr !== held_pc) begin
        value_errors++;
        $display("** Error at %0t: imem_raddr expected %h, got %h", $time, held_pc, imem_raddr);
      end
      if (imem_ren || dmem_ren) begin
        flow_errors++;
        $display("Phase %0d: memory read enable active while halted at %0t", p, $time);
      end
    end

    checks++;
    if (ebreak !== exp_eb) begin
      value_errors++;
      $display("** Error at %0t: ebreak expected %0b, got %0b", $time, exp_eb, ebreak);
    end
    if (trap !== exp_trap[p]) begin
      value_errors++;
      $display("** Error at %0t: trap expected %0b, got %0b", $time, exp_trap[p], trap);
    end
    if (idx != last) begin
      flow_errors++;
      $display("Phase %0d: %0d of %0d expected stores never appeared",
               p, last - idx, exp_len[p]);
    end
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    checks       = 0;
    value_errors = 0;
    flow_errors  = 0;
    cycle_count  = 0;
    nph          = 0;
    void'($urandom(88));
    op_a = $urandom();
    op_b = $urandom();
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] = 32'(i) * 32'h9e37_79b9;
    end
    // Operands at 0x100 and 0x104
    dmem[64] = op_a;
    dmem[65] = op_b;
    fill_imem();
    build_tables();
    cycle_limit = 20 * prog.size();

    for (int p = 0; p < NPHASES; p++) begin
      run_phase(p);
    end

    $display("Checks: %0d, value errors: %0d, flow errors: %0d",
             checks, value_errors, flow_errors);
    if (value_errors == 0 && flow_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* list.f */
+incdir+hw
hw/rv_core_pkg.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_execute.sv
hw/rv_mem_wb.sv
hw/rv_core.sv
verification/rv_core_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = rv_core_tb
FILELIST = list.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG) || (echo "Simulation failed"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
